//--- design/mby_egr_pkg.sv
/* Egress widths, queue sizes and scheduler states shared by every design file
   FIFO_DEPTH must be a power of two and at least twice MAX_PKT_WORDS */

package mby_egr_pkg;

  // ============================================================
  // Sizes
  // ============================================================

  // Ethernet transmit ports
  localparam int NUM_PORTS = 4;
  // Tag channels feeding the egress stage
  localparam int NUM_TAGS = 2;
  // Words held by one queue
  localparam int FIFO_DEPTH = 16;
  // Largest packet the admission rule reserves room for
  localparam int MAX_PKT_WORDS = 8;

  // Derived widths
  localparam int DATA_W = 64;
  localparam int PORT_W = $clog2(NUM_PORTS);
  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int COUNT_W = $clog2(FIFO_DEPTH + 1);

  // ============================================================
  // Types
  // ============================================================

  // One packet word
  typedef logic [DATA_W-1:0] data_t;

  // Destination port number, taken at sop
  typedef logic [PORT_W-1:0] port_t;

  // One bit per transmit port
  typedef logic [NUM_PORTS-1:0] port_mask_t;

  // Word count, 0 up to FIFO_DEPTH inclusive
  typedef logic [COUNT_W-1:0] count_t;

  // Queue address
  typedef logic [PTR_W-1:0] ptr_t;

  // Stored queue entry, {sop, eop, data}
  typedef logic [DATA_W+1:0] entry_t;

  // Dropped packet counter, wraps silently
  typedef logic [15:0] drop_count_t;

  // Port scheduler states
  // idle waits for a whole packet, send_tagN drains queue N up to eop
  typedef enum logic [1:0] {
    idle,
    send_tag0,
    send_tag1
  } sched_state_t;

endpackage

//--- design/mby_egr_tag_demux.sv
`timescale 1ns/1ps
/* Destination and admission are decided at sop and hold until eop
   Packets over MAX_PKT_WORDS words or a sop inside an open packet are not supported */

module mby_egr_tag_demux (
  input  logic                     egress_clock,
  input  logic                     reset,
  input  logic                     tag_valid,
  input  logic                     tag_sop,
  input  logic                     tag_eop,
  input  mby_egr_pkg::port_t       tag_dest,
  input  mby_egr_pkg::data_t       tag_data,
  input  mby_egr_pkg::count_t      free_count [mby_egr_pkg::NUM_PORTS],
  output mby_egr_pkg::port_mask_t  wr_en,
  output logic                     wr_sop,
  output logic                     wr_eop,
  output mby_egr_pkg::data_t       wr_data
);

  // Packet context latched at sop
  logic                     pkt_open;
  logic                     pkt_accept;
  mby_egr_pkg::port_t       pkt_dest;

  // Decision for the word on the input this cycle
  logic                     admit;
  logic                     word_accept;
  mby_egr_pkg::port_t       word_dest;

  // Room check at sop
  // A write still in flight to the target queue is not in its free count yet
  always_comb begin
    admit = (free_count[tag_dest] >=
             mby_egr_pkg::count_t'(mby_egr_pkg::MAX_PKT_WORDS) +
             mby_egr_pkg::count_t'(wr_en[tag_dest]));
    if (tag_sop) begin
      word_dest   = tag_dest;
      word_accept = admit;
    end else begin
      word_dest   = pkt_dest;
      word_accept = pkt_open & pkt_accept;
    end
  end

  // Control path
  always_ff @(posedge egress_clock) begin
    if (reset) begin
      pkt_open   <= 1'b0;
      pkt_accept <= 1'b0;
      pkt_dest   <= '0;
      wr_en      <= '0;
    end else begin
      wr_en <= '0;
      if (tag_valid) begin
        if (word_accept) begin
          wr_en[word_dest] <= 1'b1;
        end
        if (tag_sop) begin
          pkt_dest   <= tag_dest;
          pkt_accept <= admit;
        end
        // Single word packets never open
        pkt_open <= ~tag_eop;
      end
    end
  end

  // Payload stage, qualified by wr_en
  always_ff @(posedge egress_clock) begin
    wr_sop  <= tag_sop;
    wr_eop  <= tag_eop;
    wr_data <= tag_data;
  end

  // Words between packets must open a new one
  assert property (@(posedge egress_clock) disable iff (reset)
    (tag_valid && !pkt_open) |-> tag_sop)
    else $error("tag word outside a packet without sop");

endmodule

//--- design/mby_egr_pkt_fifo.sv
`timescale 1ns/1ps
/* Word queue with sop/eop flags, one writer and one reader
   Head data is valid while the queue is not empty, no read-during-empty protection */

module mby_egr_pkt_fifo (
  input  logic                 egress_clock,
  input  logic                 reset,
  input  logic                 wr_en,
  input  logic                 wr_sop,
  input  logic                 wr_eop,
  input  mby_egr_pkg::data_t   wr_data,
  input  logic                 rd_en,
  output logic                 rd_sop,
  output logic                 rd_eop,
  output mby_egr_pkg::data_t   rd_data,
  output mby_egr_pkg::count_t  free_count,
  output logic                 pkt_ready
);

  // ============================================================
  // Storage
  // ============================================================

  mby_egr_pkg::entry_t mem [mby_egr_pkg::FIFO_DEPTH];
  mby_egr_pkg::entry_t head;
  mby_egr_pkg::ptr_t   wr_ptr;
  mby_egr_pkg::ptr_t   rd_ptr;

  // Complete packets held, one per stored eop
  mby_egr_pkg::count_t pkt_count;

  always_ff @(posedge egress_clock) begin
    if (wr_en) begin
      mem[wr_ptr] <= {wr_sop, wr_eop, wr_data};
    end
  end

  // Head is read straight from the array
  assign head    = mem[rd_ptr];
  assign rd_sop  = head[mby_egr_pkg::DATA_W+1];
  assign rd_eop  = head[mby_egr_pkg::DATA_W];
  assign rd_data = head[mby_egr_pkg::DATA_W-1:0];

  // ============================================================
  // Pointers and counts
  // ============================================================

  always_ff @(posedge egress_clock) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      free_count <= mby_egr_pkg::count_t'(mby_egr_pkg::FIFO_DEPTH);
      pkt_count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the space unchanged
      case ({wr_en, rd_en})
        2'b10:   free_count <= free_count - 1'b1;
        2'b01:   free_count <= free_count + 1'b1;
        default: free_count <= free_count;
      endcase
      pkt_count <= pkt_count + mby_egr_pkg::count_t'(wr_en & wr_eop)
                             - mby_egr_pkg::count_t'(rd_en & rd_eop);
    end
  end

  assign pkt_ready = (pkt_count != '0);

  // Demux admission must keep writes off a full queue
  assert property (@(posedge egress_clock) disable iff (reset)
    wr_en |-> (free_count != '0))
    else $error("write into a full queue");

  // Scheduler pops only what it has seen stored
  assert property (@(posedge egress_clock) disable iff (reset)
    rd_en |-> (free_count != mby_egr_pkg::count_t'(mby_egr_pkg::FIFO_DEPTH)))
    else $error("read from an empty queue");

endmodule

//--- design/mby_egr_port_sched.sv
`timescale 1ns/1ps
/* One transmit port, two tag queues, whole packets served round robin
   Output is registered, so tx_valid follows a falling tx_enable one cycle late */

module mby_egr_port_sched (
  input  logic                                 egress_clock,
  input  logic                                 reset,
  input  logic                                 tx_enable,
  input  logic [mby_egr_pkg::NUM_TAGS-1:0]     wr_en,
  input  logic [mby_egr_pkg::NUM_TAGS-1:0]     wr_sop,
  input  logic [mby_egr_pkg::NUM_TAGS-1:0]     wr_eop,
  input  mby_egr_pkg::data_t                   wr_data [mby_egr_pkg::NUM_TAGS],
  output mby_egr_pkg::count_t                  free_count [mby_egr_pkg::NUM_TAGS],
  output logic                                 tx_valid,
  output logic                                 tx_sop,
  output logic                                 tx_eop,
  output mby_egr_pkg::data_t                   tx_data
);

  // Queue heads and pops
  logic [mby_egr_pkg::NUM_TAGS-1:0] rd_en;
  logic [mby_egr_pkg::NUM_TAGS-1:0] rd_sop;
  logic [mby_egr_pkg::NUM_TAGS-1:0] rd_eop;
  logic [mby_egr_pkg::NUM_TAGS-1:0] pkt_ready;
  mby_egr_pkg::data_t               rd_data [mby_egr_pkg::NUM_TAGS];

  // Scheduler state
  mby_egr_pkg::sched_state_t state;
  mby_egr_pkg::sched_state_t state_next;
  logic                      rr_tag;
  logic                      pick;
  logic                      pick_tag;
  logic                      rd_sel;
  logic                      pop;

  // ============================================================
  // Queues, queue n written by the demux of tag n
  // ============================================================

  for (genvar t = 0; t < mby_egr_pkg::NUM_TAGS; t++) begin : g_queue
    mby_egr_pkt_fifo u_fifo (
      .egress_clock (egress_clock),
      .reset        (reset),
      .wr_en        (wr_en[t]),
      .wr_sop       (wr_sop[t]),
      .wr_eop       (wr_eop[t]),
      .wr_data      (wr_data[t]),
      .rd_en        (rd_en[t]),
      .rd_sop       (rd_sop[t]),
      .rd_eop       (rd_eop[t]),
      .rd_data      (rd_data[t]),
      .free_count   (free_count[t]),
      .pkt_ready    (pkt_ready[t])
    );
  end

  // ============================================================
  // Packet selection and pop control
  // ============================================================

  // Favoured queue first, the other one if only it has a whole packet
  always_comb begin
    pick     = 1'b0;
    pick_tag = rr_tag;
    if (pkt_ready[rr_tag]) begin
      pick     = 1'b1;
      pick_tag = rr_tag;
    end else if (pkt_ready[~rr_tag]) begin
      pick     = 1'b1;
      pick_tag = ~rr_tag;
    end
  end

  // First word leaves with the pick, the rest one per enabled cycle
  always_comb begin
    state_next = state;
    rd_sel     = 1'b0;
    pop        = 1'b0;
    case (state)
      mby_egr_pkg::idle: begin
        if (tx_enable && pick) begin
          pop    = 1'b1;
          rd_sel = pick_tag;
          if (!rd_eop[pick_tag]) begin
            state_next = pick_tag ? mby_egr_pkg::send_tag1 : mby_egr_pkg::send_tag0;
          end
        end
      end
      mby_egr_pkg::send_tag0: begin
        pop    = tx_enable;
        rd_sel = 1'b0;
        if (tx_enable && rd_eop[0]) begin
          state_next = mby_egr_pkg::idle;
        end
      end
      mby_egr_pkg::send_tag1: begin
        pop    = tx_enable;
        rd_sel = 1'b1;
        if (tx_enable && rd_eop[1]) begin
          state_next = mby_egr_pkg::idle;
        end
      end
      default: state_next = mby_egr_pkg::idle;
    endcase
    rd_en         = '0;
    rd_en[rd_sel] = pop;
  end

  // FSM, round robin pointer and output flags
  always_ff @(posedge egress_clock) begin
    if (reset) begin
      state    <= mby_egr_pkg::idle;
      rr_tag   <= 1'b0;
      tx_valid <= 1'b0;
      tx_sop   <= 1'b0;
      tx_eop   <= 1'b0;
    end else begin
      state <= state_next;
      // Other queue gets priority at the next packet boundary
      if (state == mby_egr_pkg::idle && tx_enable && pick) begin
        rr_tag <= ~pick_tag;
      end
      tx_valid <= pop;
      tx_sop   <= pop & rd_sop[rd_sel];
      tx_eop   <= pop & rd_eop[rd_sel];
    end
  end

  // Output word register
  always_ff @(posedge egress_clock) begin
    if (pop) begin
      tx_data <= rd_data[rd_sel];
    end
  end

  // Mid-packet pops never hit the start of another packet
  assert property (@(posedge egress_clock) disable iff (reset)
    (pop && state != mby_egr_pkg::idle) |-> !rd_sop[rd_sel])
    else $error("packets mixed on transmit port");

endmodule

//--- design/mby_egr_top.sv
`timescale 1ns/1ps
/* Egress stage, two tag channels into four transmit ports
   Tag n feeds queue n of every port, no ready toward the tag sources */

module mby_egr_top (
  input  logic                egress_clock,
  input  logic                reset,
  input  logic                tag_valid_0,
  input  logic                tag_sop_0,
  input  logic                tag_eop_0,
  input  mby_egr_pkg::port_t  tag_dest_0,
  input  mby_egr_pkg::data_t  tag_data_0,
  input  logic                tag_valid_1,
  input  logic                tag_sop_1,
  input  logic                tag_eop_1,
  input  mby_egr_pkg::port_t  tag_dest_1,
  input  mby_egr_pkg::data_t  tag_data_1,
  input  logic                tx_enable_0,
  input  logic                tx_enable_1,
  input  logic                tx_enable_2,
  input  logic                tx_enable_3,
  output logic                tx_valid_0,
  output logic                tx_sop_0,
  output logic                tx_eop_0,
  output mby_egr_pkg::data_t  tx_data_0,
  output logic                tx_valid_1,
  output logic                tx_sop_1,
  output logic                tx_eop_1,
  output mby_egr_pkg::data_t  tx_data_1,
  output logic                tx_valid_2,
  output logic                tx_sop_2,
  output logic                tx_eop_2,
  output mby_egr_pkg::data_t  tx_data_2,
  output logic                tx_valid_3,
  output logic                tx_sop_3,
  output logic                tx_eop_3,
  output mby_egr_pkg::data_t  tx_data_3
);

  // Demux write side, indexed by tag
  mby_egr_pkg::port_mask_t           dmx_wr_en [mby_egr_pkg::NUM_TAGS];
  logic [mby_egr_pkg::NUM_TAGS-1:0]  dmx_wr_sop;
  logic [mby_egr_pkg::NUM_TAGS-1:0]  dmx_wr_eop;
  mby_egr_pkg::data_t                dmx_wr_data [mby_egr_pkg::NUM_TAGS];

  // Free counts seen from both sides
  mby_egr_pkg::count_t tag_free [mby_egr_pkg::NUM_TAGS][mby_egr_pkg::NUM_PORTS];
  mby_egr_pkg::count_t port_free [mby_egr_pkg::NUM_PORTS][mby_egr_pkg::NUM_TAGS];

  // Per port bundles
  logic [mby_egr_pkg::NUM_TAGS-1:0]  port_wr_en [mby_egr_pkg::NUM_PORTS];
  logic [mby_egr_pkg::NUM_PORTS-1:0] port_enable;
  logic [mby_egr_pkg::NUM_PORTS-1:0] port_valid;
  logic [mby_egr_pkg::NUM_PORTS-1:0] port_sop;
  logic [mby_egr_pkg::NUM_PORTS-1:0] port_eop;
  mby_egr_pkg::data_t                port_data [mby_egr_pkg::NUM_PORTS];

  // ============================================================
  // Tag demultiplexers
  // ============================================================

  mby_egr_tag_demux u_demux_0 (
    .egress_clock (egress_clock),
    .reset        (reset),
    .tag_valid    (tag_valid_0),
    .tag_sop      (tag_sop_0),
    .tag_eop      (tag_eop_0),
    .tag_dest     (tag_dest_0),
    .tag_data     (tag_data_0),
    .free_count   (tag_free[0]),
    .wr_en        (dmx_wr_en[0]),
    .wr_sop       (dmx_wr_sop[0]),
    .wr_eop       (dmx_wr_eop[0]),
    .wr_data      (dmx_wr_data[0])
  );

  mby_egr_tag_demux u_demux_1 (
    .egress_clock (egress_clock),
    .reset        (reset),
    .tag_valid    (tag_valid_1),
    .tag_sop      (tag_sop_1),
    .tag_eop      (tag_eop_1),
    .tag_dest     (tag_dest_1),
    .tag_data     (tag_data_1),
    .free_count   (tag_free[1]),
    .wr_en        (dmx_wr_en[1]),
    .wr_sop       (dmx_wr_sop[1]),
    .wr_eop       (dmx_wr_eop[1]),
    .wr_data      (dmx_wr_data[1])
  );

  // ============================================================
  // Port schedulers
  // ============================================================

  assign port_enable = {tx_enable_3, tx_enable_2, tx_enable_1, tx_enable_0};

  for (genvar p = 0; p < mby_egr_pkg::NUM_PORTS; p++) begin : g_port
    // Swap tag-major and port-major views
    for (genvar t = 0; t < mby_egr_pkg::NUM_TAGS; t++) begin : g_tag
      assign tag_free[t][p]   = port_free[p][t];
      assign port_wr_en[p][t] = dmx_wr_en[t][p];
    end

    mby_egr_port_sched u_sched (
      .egress_clock (egress_clock),
      .reset        (reset),
      .tx_enable    (port_enable[p]),
      .wr_en        (port_wr_en[p]),
      .wr_sop       (dmx_wr_sop),
      .wr_eop       (dmx_wr_eop),
      .wr_data      (dmx_wr_data),
      .free_count   (port_free[p]),
      .tx_valid     (port_valid[p]),
      .tx_sop       (port_sop[p]),
      .tx_eop       (port_eop[p]),
      .tx_data      (port_data[p])
    );
  end

  // Transmit ports
  assign tx_valid_0 = port_valid[0];
  assign tx_sop_0   = port_sop[0];
  assign tx_eop_0   = port_eop[0];
  assign tx_data_0  = port_data[0];
  assign tx_valid_1 = port_valid[1];
  assign tx_sop_1   = port_sop[1];
  assign tx_eop_1   = port_eop[1];
  assign tx_data_1  = port_data[1];
  assign tx_valid_2 = port_valid[2];
  assign tx_sop_2   = port_sop[2];
  assign tx_eop_2   = port_eop[2];
  assign tx_data_2  = port_data[2];
  assign tx_valid_3 = port_valid[3];
  assign tx_sop_3   = port_sop[3];
  assign tx_eop_3   = port_eop[3];
  assign tx_data_3  = port_data[3];

endmodule

//--- bench/mby_egr_tb.sv
`timescale 1ns/1ps
/* Egress testbench, commands come from bench/mby_egr_tests.txt, run from the project root
   Admission is predicted from a word-level queue model; tests keep enabled queues below half full */

module mby_egr_tb;

  // ============================================================
  // DUT signals
  // ============================================================

  logic                     egress_clock;
  logic                     reset;
  logic                     tag_valid_0;
  logic                     tag_sop_0;
  logic                     tag_eop_0;
  mby_egr_pkg::port_t       tag_dest_0;
  mby_egr_pkg::data_t       tag_data_0;
  logic                     tag_valid_1;
  logic                     tag_sop_1;
  logic                     tag_eop_1;
  mby_egr_pkg::port_t       tag_dest_1;
  mby_egr_pkg::data_t       tag_data_1;
  mby_egr_pkg::port_mask_t  tx_enable;
  mby_egr_pkg::port_mask_t  tx_valid;
  mby_egr_pkg::port_mask_t  tx_sop;
  mby_egr_pkg::port_mask_t  tx_eop;
  mby_egr_pkg::data_t       tx_data [mby_egr_pkg::NUM_PORTS];

  // ============================================================
  // Model and scoreboard state, queue index is port * NUM_TAGS + tag
  // ============================================================

  mby_egr_pkg::data_t       exp_words [mby_egr_pkg::NUM_PORTS*mby_egr_pkg::NUM_TAGS][$];
  int                       exp_len [mby_egr_pkg::NUM_PORTS*mby_egr_pkg::NUM_TAGS][$];
  int                       occ [mby_egr_pkg::NUM_PORTS*mby_egr_pkg::NUM_TAGS];
  // Packets waiting to be sent, dest * 16 + len
  int                       pend [mby_egr_pkg::NUM_TAGS][$];
  // Per port receive state
  mby_egr_pkg::port_mask_t  in_pkt;
  mby_egr_pkg::port_mask_t  en_prev;
  int                       cur_q [mby_egr_pkg::NUM_PORTS];
  int                       cur_len [mby_egr_pkg::NUM_PORTS];
  int                       cur_cnt [mby_egr_pkg::NUM_PORTS];
  int                       port_pkts [mby_egr_pkg::NUM_PORTS];
  logic [31:0]              lcg_state;
  logic [31:0]              seq_next;

  mby_egr_top UUT (
    .egress_clock (egress_clock),
    .reset        (reset),
    .tag_valid_0  (tag_valid_0),
    .tag_sop_0    (tag_sop_0),
    .tag_eop_0    (tag_eop_0),
    .tag_dest_0   (tag_dest_0),
    .tag_data_0   (tag_data_0),
    .tag_valid_1  (tag_valid_1),
    .tag_sop_1    (tag_sop_1),
    .tag_eop_1    (tag_eop_1),
    .tag_dest_1   (tag_dest_1),
    .tag_data_1   (tag_data_1),
    .tx_enable_0  (tx_enable[0]),
    .tx_enable_1  (tx_enable[1]),
    .tx_enable_2  (tx_enable[2]),
    .tx_enable_3  (tx_enable[3]),
    .tx_valid_0   (tx_valid[0]),
    .tx_sop_0     (tx_sop[0]),
    .tx_eop_0     (tx_eop[0]),
    .tx_data_0    (tx_data[0]),
    .tx_valid_1   (tx_valid[1]),
    .tx_sop_1     (tx_sop[1]),
    .tx_eop_1     (tx_eop[1]),
    .tx_data_1    (tx_data[1]),
    .tx_valid_2   (tx_valid[2]),
    .tx_sop_2     (tx_sop[2]),
    .tx_eop_2     (tx_eop[2]),
    .tx_data_2    (tx_data[2]),
    .tx_valid_3   (tx_valid[3]),
    .tx_sop_3     (tx_sop[3]),
    .tx_eop_3     (tx_eop[3]),
    .tx_data_3    (tx_data[3])
  );

  // 4 ns period
  always #2 egress_clock = ~egress_clock;

  // ============================================================
  // Reporting and compare tasks
  // ============================================================

  task automatic end_run_failed();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic stop_with_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    end_run_failed();
  endtask

  task automatic check_data(input mby_egr_pkg::data_t actual,
                            input mby_egr_pkg::data_t expected, input string what);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      end_run_failed();
    end
  endtask

  task automatic check_port(input mby_egr_pkg::port_t actual,
                            input mby_egr_pkg::port_t expected, input string what);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
      end_run_failed();
    end
  endtask

  task automatic check_count(input mby_egr_pkg::count_t actual,
                             input mby_egr_pkg::count_t expected, input string what);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
      end_run_failed();
    end
  endtask

  // Numerical Recipes constants
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int pending_words();
    int total;
    total = 0;
    for (int q = 0; q < mby_egr_pkg::NUM_PORTS * mby_egr_pkg::NUM_TAGS; q++) begin
      total += exp_words[q].size();
    end
    return total;
  endfunction

  // ============================================================
  // Stimulus
  // ============================================================

  task automatic drive_word(input int ch, input logic valid, input logic sop,
                            input logic eop, input mby_egr_pkg::port_t dest,
                            input mby_egr_pkg::data_t data);
    if (ch == 0) begin
      tag_valid_0 <= valid;
      tag_sop_0   <= sop;
      tag_eop_0   <= eop;
      tag_dest_0  <= dest;
      tag_data_0  <= data;
    end else begin
      tag_valid_1 <= valid;
      tag_sop_1   <= sop;
      tag_eop_1   <= eop;
      tag_dest_1  <= dest;
      tag_data_1  <= data;
    end
  endtask

  // One packet, header then LCG payload, random single-cycle gaps
  task automatic send_packet(input int ch, input int dest, input int len);
    mby_egr_pkg::data_t word;
    logic [31:0]        hi;
    logic [31:0]        lo;
    logic [31:0]        gap;
    int                 q;
    bit                 admitted;
    q        = dest * mby_egr_pkg::NUM_TAGS + ch;
    admitted = 1'b0;
    for (int i = 0; i < len; i++) begin
      if (i == 0) begin
        word     = {ch[1:0], dest[1:0], len[3:0], 24'h0, seq_next};
        seq_next = seq_next + 32'd1;
      end else begin
        hi   = lcg_next();
        lo   = lcg_next();
        word = {hi, lo};
        gap  = lcg_next();
        if (gap[2:0] == 3'd0) begin
          @(posedge egress_clock);
          drive_word(ch, 1'b0, 1'b0, 1'b0, '0, '0);
        end
      end
      @(posedge egress_clock);
      // Room for a largest packet at sop, else the whole packet is lost
      if (i == 0) begin
        admitted = (mby_egr_pkg::FIFO_DEPTH - occ[q]) >= mby_egr_pkg::MAX_PKT_WORDS;
        if (admitted) begin
          occ[q] += len;
          exp_len[q].push_back(len);
        end
      end
      if (admitted) begin
        exp_words[q].push_back(word);
      end
      drive_word(ch, 1'b1, i == 0, i == len - 1, dest[1:0], word);
    end
    @(posedge egress_clock);
    drive_word(ch, 1'b0, 1'b0, 1'b0, '0, '0);
  endtask

  task automatic send_all(input int ch);
    int cmd;
    while (pend[ch].size() > 0) begin
      cmd = pend[ch].pop_front();
      send_packet(ch, cmd / 16, cmd % 16);
    end
  endtask

  // Both channels run side by side
  task automatic flush_sends();
    fork
      send_all(0);
      send_all(1);
    join
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (pending_words() != 0 || in_pkt != '0) begin
      if (cycles >= 2000) begin
        stop_with_error("timeout waiting for expected packets to leave");
      end
      @(posedge egress_clock);
      cycles++;
    end
  endtask

  // ============================================================
  // Output monitor, sampled mid-cycle
  // ============================================================

  task automatic watch_port(input int p);
    int                 ch;
    int                 q;
    mby_egr_pkg::data_t expected;
    if (tx_valid[p]) begin
      if (!en_prev[p]) begin
        stop_with_error($sformatf("port %0d sent a word while its enable was low", p));
      end
      if (tx_sop[p]) begin
        if (in_pkt[p]) begin
          stop_with_error($sformatf("port %0d started a packet inside another", p));
        end
        ch = int'(tx_data[p][63:62]);
        if (ch >= mby_egr_pkg::NUM_TAGS) begin
          stop_with_error($sformatf("port %0d header names a bad channel", p));
        end
        check_port(tx_data[p][61:60], mby_egr_pkg::port_t'(p), "header destination");
        cur_q[p] = p * mby_egr_pkg::NUM_TAGS + ch;
        if (exp_len[cur_q[p]].size() == 0) begin
          stop_with_error($sformatf("port %0d sent a packet nobody expected", p));
        end
        cur_len[p] = exp_len[cur_q[p]].pop_front();
        cur_cnt[p] = 0;
        in_pkt[p]  = 1'b1;
      end else if (!in_pkt[p]) begin
        stop_with_error($sformatf("port %0d sent a word outside a packet", p));
      end
      q        = cur_q[p];
      expected = exp_words[q].pop_front();
      check_data(tx_data[p], expected, $sformatf("port %0d word %0d", p, cur_cnt[p]));
      cur_cnt[p]++;
      occ[q]--;
      if (tx_eop[p]) begin
        check_count(mby_egr_pkg::count_t'(cur_cnt[p]),
                    mby_egr_pkg::count_t'(cur_len[p]), "packet length");
        in_pkt[p] = 1'b0;
        port_pkts[p]++;
      end else if (cur_cnt[p] >= cur_len[p]) begin
        stop_with_error($sformatf("port %0d packet ran past its length", p));
      end
    end else if (in_pkt[p] && en_prev[p]) begin
      // Whole packets are stored, so an enabled port never stalls mid-packet
      stop_with_error($sformatf("port %0d paused inside a packet while enabled", p));
    end
  endtask

  always @(negedge egress_clock) begin
    if (!reset) begin
      for (int p = 0; p < mby_egr_pkg::NUM_PORTS; p++) begin
        watch_port(p);
      end
    end
    // tx_valid lags tx_enable by one cycle
    en_prev = tx_enable;
  end

  // ============================================================
  // Command file
  // ============================================================

  task automatic run_tests();
    int          fd;
    int          code;
    string       line;
    logic [7:0]  cmd;
    int          a;
    int          b;
    int          c;
    int          e [4];
    fd = $fopen("bench/mby_egr_tests.txt", "r");
    if (fd == 0) begin
      stop_with_error("cannot open bench/mby_egr_tests.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      if (code == 0 || line.len() < 1 || line[0] == "#" || line[0] == 8'h0a) begin
        continue;
      end
      code = $sscanf(line, "%c", cmd);
      case (cmd)
        "P": begin
          code = $sscanf(line, "%c %d %d %d", cmd, a, b, c);
          if (code != 4 || a > 1 || b > 3 || c < 1 || c > mby_egr_pkg::MAX_PKT_WORDS) begin
            stop_with_error({"malformed packet command: ", line});
          end
          pend[a].push_back(b * 16 + c);
        end
        "E": begin
          flush_sends();
          code = $sscanf(line, "%c %h", cmd, a);
          @(posedge egress_clock);
          tx_enable <= a[3:0];
        end
        "D": begin
          flush_sends();
          wait_drain();
        end
        "C": begin
          flush_sends();
          code = $sscanf(line, "%c %d %d %d %d", cmd, e[0], e[1], e[2], e[3]);
          for (int p = 0; p < mby_egr_pkg::NUM_PORTS; p++) begin
            check_count(mby_egr_pkg::count_t'(port_pkts[p]),
                        mby_egr_pkg::count_t'(e[p]), $sformatf("packets on port %0d", p));
            port_pkts[p] = 0;
          end
        end
        default: stop_with_error({"unknown command: ", line});
      endcase
    end
    $fclose(fd);
  endtask

  initial begin
    egress_clock = 1'b0;
    reset        = 1'b1;
    tx_enable    = '1;
    en_prev      = '0;
    in_pkt       = '0;
    lcg_state    = 32'hdca7;
    seq_next     = 32'd0;
    drive_word(0, 1'b0, 1'b0, 1'b0, '0, '0);
    drive_word(1, 1'b0, 1'b0, 1'b0, '0, '0);
    for (int q = 0; q < mby_egr_pkg::NUM_PORTS * mby_egr_pkg::NUM_TAGS; q++) begin
      occ[q] = 0;
    end
    for (int p = 0; p < mby_egr_pkg::NUM_PORTS; p++) begin
      port_pkts[p] = 0;
    end
    repeat (10) @(posedge egress_clock);
    reset <= 1'b0;
    // Quiet ports straight after reset
    for (int i = 0; i < 8; i++) begin
      @(negedge egress_clock);
      if (tx_valid != '0) begin
        stop_with_error("tx_valid seen after reset before any packet was sent");
      end
    end
    run_tests();
    flush_sends();
    wait_drain();
    $display("All tests passed!");
    $finish;
  end

endmodule

//--- bench/mby_egr_tests.txt
# Egress commands: P chan dest len | E enable_mask_hex | D drain | C pkts_p0 pkts_p1 pkts_p2 pkts_p3
# C counts are packets seen on each port since the previous C
E f
# Routing, both channels to every port
P 0 0 1
P 0 1 2
P 0 2 3
P 0 3 4
P 0 0 5
P 1 0 8
P 1 1 7
P 1 2 6
P 1 3 5
D
C 3 2 2 2
# Order and interleave, both channels into port 1
P 0 1 2
P 1 1 4
P 0 1 3
P 1 1 4
P 0 1 3
D
C 0 5 0 0
# Single word packets into port 2
P 0 2 1
P 1 2 1
P 0 2 1
P 1 2 1
P 0 2 1
D
C 0 0 5 0
# Largest packets into port 3
P 0 3 8
P 1 3 7
P 0 3 8
P 1 3 8
D
C 0 0 0 4
# Back-pressure, port 2 held off while loaded
E b
P 0 2 4
P 1 2 6
P 0 2 3
P 1 2 2
P 1 3 5
E f
D
C 0 0 4 1
# Drop, port 0 held off, only two 8 word packets fit in queue 0
E e
P 0 0 8
P 0 0 8
P 0 0 8
P 0 0 8
P 1 0 8
E f
D
C 3 0 0 0
P 0 0 8
D
C 1 0 0 0

//--- build.f
design/mby_egr_pkg.sv
design/mby_egr_tag_demux.sv
design/mby_egr_pkt_fifo.sv
design/mby_egr_port_sched.sv
design/mby_egr_top.sv
bench/mby_egr_tb.sv

//--- Makefile
# Verilator build and run of the egress testbench

SIM      := verilator
SIMFLAGS := --binary --timing --assert -j 0
TOP      := mby_egr_tb
FILELIST := build.f
OBJDIR   := obj_dir
LOG      := sim.log
FAIL_MSG := Test failures found

.PHONY: sim clean

sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJDIR) $(LOG)
